// ==== logic/phy_rx_pkg.sv ====
// receive PCS shared definitions: block layout, sync header codes, BER limit, register map
package phy_rx_pkg;

    // block layout, bit 0 is first on the wire
    localparam int hdr_w   = 2;
    localparam int data_w  = 64;
    localparam int block_w = hdr_w + data_w;

    // sync header codes
    localparam logic [hdr_w-1:0] sync_data = 2'b10;
    localparam logic [hdr_w-1:0] sync_ctrl = 2'b01;

    // invalid headers in one BER window that raise hi_ber
    localparam int ber_limit = 16;

    // APB register port
    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // register offsets
    localparam logic [apb_addr_w-1:0] reg_status    = 8'h00;
    localparam logic [apb_addr_w-1:0] reg_hdr_err   = 8'h04;
    localparam logic [apb_addr_w-1:0] reg_slip_cnt  = 8'h08;
    localparam logic [apb_addr_w-1:0] reg_lock_loss = 8'h0C;
    localparam logic [apb_addr_w-1:0] reg_ctrl      = 8'h10;

endpackage

// ==== logic/rx_bitslip_aligner.sv ====
// bit-slip aligner: cuts a 66-bit block out of two neighbouring raw words at a slip offset
`timescale 1ns/1ps

module rx_bitslip_aligner
    import phy_rx_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic [block_w-1:0] raw_data,
    input  logic               raw_valid,
    input  logic               bitslip,
    output logic [hdr_w-1:0]   blk_hdr,
    output logic [data_w-1:0]  blk_data,
    output logic               blk_valid
);

    localparam int off_w = $clog2(block_w);

    logic [block_w-1:0]   prev_word;
    logic [2*block_w-1:0] pair;
    logic [block_w-1:0]   window;
    logic [off_w-1:0]     offset;
    logic                 bitslip_d;

    // older word in the low half since bit 0 arrives first
    assign pair   = {raw_data, prev_word};
    assign window = pair[offset +: block_w];

    // one slip per pulse, taken on its rising edge
    always_ff @(posedge clk) begin
        if (rst) begin
            offset    <= '0;
            bitslip_d <= 1'b0;
            blk_valid <= 1'b0;
        end else begin
            bitslip_d <= bitslip;
            blk_valid <= raw_valid;
            if (bitslip && !bitslip_d) begin
                if (offset == off_w'(block_w - 1)) begin
                    offset <= '0;
                end else begin
                    offset <= offset + 1'b1;
                end
            end
        end
    end

    // barrel shift result, header in the two low bits
    always_ff @(posedge clk) begin
        if (raw_valid) begin
            prev_word <= raw_data;
            blk_hdr   <= window[hdr_w-1:0];
            blk_data  <= window[block_w-1:hdr_w];
        end
    end

    offset_in_range: assert property (@(posedge clk) disable iff (rst)
        offset < off_w'(block_w))
        else $error("slip offset left the block range");

endmodule

// ==== logic/rx_frame_sync.sv ====
// frame sync: hunts for sync headers, pulses bitslip and reports block lock
`timescale 1ns/1ps

module rx_frame_sync
    import phy_rx_pkg::*;
#(
    parameter int bitslip_high_cycles = 1,
    parameter int bitslip_low_cycles  = 7
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [hdr_w-1:0] blk_hdr,
    input  logic             blk_valid,
    output logic             bitslip,
    output logic             block_lock
);

    localparam int hold_max = (bitslip_high_cycles - 1 > bitslip_low_cycles) ?
                              bitslip_high_cycles - 1 : bitslip_low_cycles;
    localparam int hold_w   = (hold_max > 0) ? $clog2(hold_max + 1) : 1;

    logic [5:0]        sh_cnt;
    logic [5:0]        sh_cnt_next;
    logic [3:0]        bad_cnt;
    logic [3:0]        bad_cnt_next;
    logic [hold_w-1:0] hold_cnt;
    logic [hold_w-1:0] hold_cnt_next;
    logic              bitslip_next;
    logic              block_lock_next;
    logic              hdr_ok;

    assign hdr_ok = (blk_hdr == sync_data) || (blk_hdr == sync_ctrl);

    always_comb begin
        sh_cnt_next     = sh_cnt;
        bad_cnt_next    = bad_cnt;
        hold_cnt_next   = hold_cnt;
        bitslip_next    = bitslip;
        block_lock_next = block_lock;

        if (hold_cnt != '0) begin
            // slip pulse or settle time still running
            hold_cnt_next = hold_cnt - 1'b1;
        end else if (bitslip) begin
            // pulse over, give the aligner time to refill
            bitslip_next  = 1'b0;
            hold_cnt_next = hold_w'(bitslip_low_cycles);
        end else if (blk_valid) begin
            sh_cnt_next = sh_cnt + 1'b1;
            if (!hdr_ok) begin
                bad_cnt_next = bad_cnt + 1'b1;
            end

            if (!hdr_ok && (!block_lock || bad_cnt == 4'd15)) begin
                // any error while hunting, or the 16th error of a locked window
                sh_cnt_next     = '0;
                bad_cnt_next    = '0;
                block_lock_next = 1'b0;
                bitslip_next    = 1'b1;
                hold_cnt_next   = hold_w'(bitslip_high_cycles - 1);
            end else if (sh_cnt == 6'd63) begin
                // end of a 64-header window
                sh_cnt_next  = '0;
                bad_cnt_next = '0;
                if (hdr_ok && bad_cnt == '0) begin
                    block_lock_next = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sh_cnt     <= '0;
            bad_cnt    <= '0;
            hold_cnt   <= '0;
            bitslip    <= 1'b0;
            block_lock <= 1'b0;
        end else begin
            sh_cnt     <= sh_cnt_next;
            bad_cnt    <= bad_cnt_next;
            hold_cnt   <= hold_cnt_next;
            bitslip    <= bitslip_next;
            block_lock <= block_lock_next;
        end
    end

    slip_pulse_width: assert property (@(posedge clk) disable iff (rst)
        $rose(bitslip) |-> ##(bitslip_high_cycles) !bitslip)
        else $error("bitslip held past its pulse width");

endmodule

// ==== logic/rx_descrambler.sv ====
// self-synchronizing descrambler for x^58 + x^39 + 1 with a bypass path
`timescale 1ns/1ps

module rx_descrambler
    import phy_rx_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [hdr_w-1:0]  blk_hdr,
    input  logic [data_w-1:0] blk_data,
    input  logic              blk_valid,
    input  logic              block_lock,
    input  logic              descramble_bypass,
    output logic [hdr_w-1:0]  rx_hdr,
    output logic [data_w-1:0] rx_data,
    output logic              rx_valid
);

    localparam int scr_w   = 58;
    localparam int scr_tap = 39;

    // last 58 scrambled bits received, bit scr_w-1 the newest
    logic [scr_w-1:0]        hist;
    logic [scr_w+data_w-1:0] ext;
    logic [data_w-1:0]       descr;

    assign ext = {blk_data, hist};

    // each bit xors with the bits received 39 and 58 places earlier
    always_comb begin
        for (int i = 0; i < data_w; i++) begin
            descr[i] = ext[scr_w + i] ^ ext[scr_w - scr_tap + i] ^ ext[i];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= blk_valid && block_lock;
        end
    end

    // history keeps running before lock so the output is clean once locked
    always_ff @(posedge clk) begin
        if (blk_valid) begin
            hist    <= blk_data[data_w-1:data_w-scr_w];
            rx_hdr  <= blk_hdr;
            rx_data <= descramble_bypass ? blk_data : descr;
        end
    end

endmodule

// ==== logic/rx_ber_monitor.sv ====
// BER monitor: counts invalid sync headers per window and raises hi_ber
`timescale 1ns/1ps

module rx_ber_monitor
    import phy_rx_pkg::*;
#(
    parameter int ber_window = 1024
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [hdr_w-1:0] blk_hdr,
    input  logic             blk_valid,
    input  logic             block_lock,
    output logic             hdr_err,
    output logic             hi_ber
);

    localparam int win_w = (ber_window > 1) ? $clog2(ber_window) : 1;
    localparam int cnt_w = $clog2(ber_limit + 1);

    logic [win_w-1:0] win_cnt;
    logic [cnt_w-1:0] err_cnt;
    logic [cnt_w:0]   err_total;
    logic             hdr_bad;
    logic             win_end;

    assign hdr_bad = (blk_hdr != sync_data) && (blk_hdr != sync_ctrl);
    assign win_end = (win_cnt == win_w'(ber_window - 1));

    // a pulse in the last cycle still belongs to the closing window
    assign err_total = {1'b0, err_cnt} + {{cnt_w{1'b0}}, hdr_err};

    always_ff @(posedge clk) begin
        if (rst) begin
            win_cnt <= '0;
            err_cnt <= '0;
            hdr_err <= 1'b0;
            hi_ber  <= 1'b0;
        end else begin
            hdr_err <= blk_valid && block_lock && hdr_bad;
            if (win_end) begin
                win_cnt <= '0;
                err_cnt <= '0;
                hi_ber  <= int'(err_total) >= ber_limit;
            end else begin
                win_cnt <= win_cnt + 1'b1;
                // saturate at the limit
                if (hdr_err && err_cnt != cnt_w'(ber_limit)) begin
                    err_cnt <= err_cnt + 1'b1;
                end
            end
        end
    end

    hdr_err_needs_lock: assert property (@(posedge clk) disable iff (rst)
        hdr_err |-> $past(block_lock))
        else $error("header error counted without block lock");

endmodule

// ==== logic/rx_status_regs.sv ====
// APB register block: lock and BER status, error counters, descrambler bypass control
`timescale 1ns/1ps

module rx_status_regs
    import phy_rx_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    input  logic                  block_lock,
    input  logic                  hi_ber,
    input  logic                  hdr_err,
    input  logic                  bitslip,
    output logic                  descramble_bypass
);

    logic        access;
    logic        wr_en;
    logic        mapped;
    logic [15:0] hdr_err_cnt;
    logic [15:0] slip_cnt;
    logic [7:0]  lock_loss_cnt;
    logic        bitslip_d;
    logic        lock_d;
    logic        slip_rise;
    logic        lock_fall;

    assign access    = psel && penable;
    assign wr_en     = access && pwrite;
    assign slip_rise = bitslip && !bitslip_d;
    assign lock_fall = lock_d && !block_lock;

    // no wait states
    assign pready  = 1'b1;
    assign pslverr = access && !mapped;

    always_comb begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            reg_status:    prdata[1:0]  = {hi_ber, block_lock};
            reg_hdr_err:   prdata[15:0] = hdr_err_cnt;
            reg_slip_cnt:  prdata[15:0] = slip_cnt;
            reg_lock_loss: prdata[7:0]  = lock_loss_cnt;
            reg_ctrl:      prdata[0]    = descramble_bypass;
            default:       mapped       = 1'b0;
        endcase
    end

    // saturating counters, any write to a counter clears it
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_err_cnt       <= '0;
            slip_cnt          <= '0;
            lock_loss_cnt     <= '0;
            bitslip_d         <= 1'b0;
            lock_d            <= 1'b0;
            descramble_bypass <= 1'b0;
        end else begin
            bitslip_d <= bitslip;
            lock_d    <= block_lock;

            if (wr_en && paddr == reg_hdr_err) begin
                hdr_err_cnt <= '0;
            end else if (hdr_err && hdr_err_cnt != '1) begin
                hdr_err_cnt <= hdr_err_cnt + 1'b1;
            end

            if (wr_en && paddr == reg_slip_cnt) begin
                slip_cnt <= '0;
            end else if (slip_rise && slip_cnt != '1) begin
                slip_cnt <= slip_cnt + 1'b1;
            end

            if (wr_en && paddr == reg_lock_loss) begin
                lock_loss_cnt <= '0;
            end else if (lock_fall && lock_loss_cnt != '1) begin
                lock_loss_cnt <= lock_loss_cnt + 1'b1;
            end

            if (wr_en && paddr == reg_ctrl) begin
                descramble_bypass <= pwdata[0];
            end
        end
    end

    // access phase only after a setup cycle
    apb_setup_first: assert property (@(posedge clk) disable iff (rst)
        $rose(penable) |-> psel && $past(psel))
        else $error("penable rose without a setup cycle");

endmodule

// ==== logic/phy_rx_top.sv ====
// 10GBASE-R receive PCS top: aligner, frame sync, descrambler, BER monitor and registers
`timescale 1ns/1ps

module phy_rx_top
    import phy_rx_pkg::*;
#(
    parameter int bitslip_high_cycles = 1,
    parameter int bitslip_low_cycles  = 7,
    parameter int ber_window          = 1024
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [block_w-1:0]    raw_data,
    input  logic                  raw_valid,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    output logic [hdr_w-1:0]      rx_hdr,
    output logic [data_w-1:0]     rx_data,
    output logic                  rx_valid,
    output logic                  block_lock,
    output logic                  hi_ber
);

    // aligned blocks, shared by sync, descrambler and BER monitor
    logic [hdr_w-1:0]  blk_hdr;
    logic [data_w-1:0] blk_data;
    logic              blk_valid;

    logic bitslip;
    logic hdr_err;
    logic descramble_bypass;

    rx_bitslip_aligner i_bitslip_aligner (
        .clk       (clk),
        .rst       (rst),
        .raw_data  (raw_data),
        .raw_valid (raw_valid),
        .bitslip   (bitslip),
        .blk_hdr   (blk_hdr),
        .blk_data  (blk_data),
        .blk_valid (blk_valid)
    );

    rx_frame_sync #(
        .bitslip_high_cycles (bitslip_high_cycles),
        .bitslip_low_cycles  (bitslip_low_cycles)
    ) i_frame_sync (
        .clk        (clk),
        .rst        (rst),
        .blk_hdr    (blk_hdr),
        .blk_valid  (blk_valid),
        .bitslip    (bitslip),
        .block_lock (block_lock)
    );

    rx_descrambler i_descrambler (
        .clk               (clk),
        .rst               (rst),
        .blk_hdr           (blk_hdr),
        .blk_data          (blk_data),
        .blk_valid         (blk_valid),
        .block_lock        (block_lock),
        .descramble_bypass (descramble_bypass),
        .rx_hdr            (rx_hdr),
        .rx_data           (rx_data),
        .rx_valid          (rx_valid)
    );

    rx_ber_monitor #(
        .ber_window (ber_window)
    ) i_ber_monitor (
        .clk        (clk),
        .rst        (rst),
        .blk_hdr    (blk_hdr),
        .blk_valid  (blk_valid),
        .block_lock (block_lock),
        .hdr_err    (hdr_err),
        .hi_ber     (hi_ber)
    );

    rx_status_regs i_status_regs (
        .clk               (clk),
        .rst               (rst),
        .paddr             (paddr),
        .psel              (psel),
        .penable           (penable),
        .pwrite            (pwrite),
        .pwdata            (pwdata),
        .prdata            (prdata),
        .pready            (pready),
        .pslverr           (pslverr),
        .block_lock        (block_lock),
        .hi_ber            (hi_ber),
        .hdr_err           (hdr_err),
        .bitslip           (bitslip),
        .descramble_bypass (descramble_bypass)
    );

endmodule

// ==== test/phy_rx_tb.sv ====
// receive PCS testbench: scrambled block transmitter, header error injection, APB checks
`timescale 1ns/1ps

module phy_rx_tb;
    import phy_rx_pkg::*;

    localparam int ber_window  = 256;
    localparam int acq_blocks  = 66 * (8 + 64) + 64;
    // raw_valid drops cost cycles, so waits allow twice the block count
    localparam int test_cycles = 2 * acq_blocks + 600 + 400 + 2 * acq_blocks + 100
                               + 600 + 3 * ber_window + 600 + 100;
    localparam int cycle_limit = test_cycles * 12 / 10;

    logic clk = 1'b0;
    logic rst;
    logic [block_w-1:0] raw_data;
    logic raw_valid;
    logic [apb_addr_w-1:0] paddr;
    logic psel, penable, pwrite;
    logic [apb_data_w-1:0] pwdata, prdata;
    logic pready, pslverr;
    logic [hdr_w-1:0] rx_hdr;
    logic [data_w-1:0] rx_data;
    logic rx_valid, block_lock, hi_ber;

    int seed = 32'h53e37a72;
    int errors = 0;
    int err_mark = 0;
    int tests_ok = 0;
    int tests_bad = 0;
    int cycles = 0;

    // transmitter state
    logic [57:0]        tx_hist = '0;
    logic [63:0]        tx_cnt = '0;
    logic [block_w-1:0] tx_prev = '0;
    int tx_off;
    int tx_idx = 0;
    int bad_req = 0;
    int bad_sent = 0;
    int bad_gap = 1;
    int bad_first = 0;
    logic [hdr_w-1:0]  hdr_mem [1024];
    logic [data_w-1:0] scr_mem [1024];

    // payload tracking
    logic [63:0] exp_cnt = '0;
    logic armed = 1'b0;
    logic pay_hold = 1'b0;
    logic bypass_exp = 1'b0;
    logic hold_chk = 1'b0;
    logic slip_d = 1'b0;
    int slips_seen = 0;
    logic [data_w-1:0] exp_word;
    logic [hdr_w-1:0]  exp_hdr;
    // sync windows start at the first block delivered after lock
    logic [5:0] win_pos0 = '0;
    logic [1:0] raw_valid_d = '0;
    logic lock_q = 1'b0;
    logic exp_valid;

    phy_rx_top #(.ber_window(ber_window)) i_phy_rx_top (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    // scrambles the counter, adds a header and lays blocks into the raw stream
    always @(posedge clk) begin
        logic [121:0] ext;
        logic [hdr_w-1:0] hdr;
        logic [2*block_w-1:0] pair;
        #1;
        raw_valid = !rst && (($random(seed) & 7) != 0);
        if (raw_valid) begin
            ext[57:0] = tx_hist;
            for (int i = 0; i < 64; i++) begin
                ext[58+i] = tx_cnt[i] ^ ext[19+i] ^ ext[i];
            end
            tx_hist = ext[121:64];
            hdr = (($random(seed) & 1) != 0) ? sync_data : sync_ctrl;
            // first error of a burst lands at the start of a sync window
            if (bad_sent < bad_req && (tx_idx % bad_gap) == 0
                    && (bad_sent != bad_first || tx_cnt[5:0] == win_pos0)) begin
                hdr = tx_idx[0] ? 2'b11 : 2'b00;
                bad_sent++;
            end
            hdr_mem[tx_cnt[9:0]] = hdr;
            scr_mem[tx_cnt[9:0]] = ext[121:58];
            pair = {ext[121:58], hdr, tx_prev};
            raw_data = pair[tx_off +: block_w];
            tx_prev = {ext[121:58], hdr};
            tx_cnt++;
            tx_idx++;
        end
    end

    // follows the received counter and counts slip pulses
    always @(posedge clk) begin
        slip_d <= i_phy_rx_top.bitslip;
        raw_valid_d <= {raw_valid_d[0], raw_valid};
        lock_q <= block_lock;
        if (i_phy_rx_top.bitslip && !slip_d) slips_seen <= slips_seen + 1;
        if (!block_lock) begin
            armed <= 1'b0;
        end else if (rx_valid) begin
            armed   <= 1'b1;
            exp_cnt <= armed ? exp_cnt + 64'd1 : rx_data + 64'd1;
            if (!armed) begin
                win_pos0 <= rx_data[5:0];
            end
        end
    end

    assign exp_word  = bypass_exp ? scr_mem[exp_cnt[9:0]] : exp_cnt;
    assign exp_hdr   = hdr_mem[exp_cnt[9:0]];
    // two cycles from a raw word, only while locked
    assign exp_valid = raw_valid_d[1] && lock_q;

    payload_data: assert property (@(posedge clk) disable iff (rst)
        (rx_valid && armed && !pay_hold) |-> rx_data == exp_word)
        else begin
            $display("** Error at %0t: rx_data expected %h actual %h",
                     $time, $sampled(exp_word), $sampled(rx_data));
            errors++;
        end

    payload_hdr: assert property (@(posedge clk) disable iff (rst)
        (rx_valid && armed && !pay_hold) |-> rx_hdr == exp_hdr)
        else begin
            $display("** Error at %0t: rx_hdr expected %b actual %b",
                     $time, $sampled(exp_hdr), $sampled(rx_hdr));
            errors++;
        end

    rx_valid_gate: assert property (@(posedge clk) disable iff (rst) rx_valid == exp_valid)
        else begin
            $display("** Error at %0t: rx_valid expected %b actual %b",
                     $time, $sampled(exp_valid), $sampled(rx_valid));
            errors++;
        end

    lock_held: assert property (@(posedge clk) disable iff (rst) hold_chk |-> block_lock)
        else begin
            $display("block_lock dropped at %0t while errors stayed below the limit", $time);
            errors++;
        end

    task automatic check_equal(input string name, input logic [31:0] exp, input logic [31:0] act);
        value_ok: assert (exp == act)
        else begin
            $display("** Error at %0t: %s expected %0h actual %0h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        cond_ok: assert (cond)
        else begin
            $display("%s at %0t", what, $time);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        if (errors == err_mark) begin
            $display("test %s ok", name);
            tests_ok++;
        end else begin
            $display("test %s FAILED", name);
            tests_bad++;
        end
        err_mark = errors;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
        @(posedge clk);
        #1;
        paddr = addr;
        pwrite = 1'b0;
        psel = 1'b1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        data = prdata;
        err = pslverr;
        check_true(pready, "pready low in an APB read access");
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        paddr = addr;
        pwdata = data;
        pwrite = 1'b1;
        psel = 1'b1;
        @(posedge clk);
        #1;
        penable = 1'b1;
        #1;
        check_true(pready, "pready low in an APB write access");
        @(posedge clk);
        #1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    // limit counts accepted raw words
    task automatic wait_lock(input logic level, input int limit);
        int n;
        n = 0;
        while (block_lock !== level && n < limit) begin
            @(posedge clk);
            if (raw_valid) n++;
        end
    endtask

    task automatic inject(input int count, input int gap);
        bad_gap = gap;
        bad_first = bad_sent;
        bad_req = bad_sent + count;
        while (bad_sent < bad_req) @(posedge clk);
        repeat (10) @(posedge clk);
    endtask

    initial begin
        logic [31:0] rd;
        logic err;
        int loss_before;
        tx_off = {$random(seed)} % block_w;
        rst = 1'b1;
        raw_data = '0;
        raw_valid = 1'b0;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        wait_lock(1'b1, acq_blocks);
        check_true(block_lock, "block lock not reached within the slip limit");
        apb_read(reg_slip_cnt, rd, err);
        check_equal("reg_slip_cnt", 32'(slips_seen), rd);
        finish_test("acquisition");

        while (!armed) @(posedge clk);
        repeat (200) @(posedge clk);
        pay_hold = 1'b1;
        apb_write(reg_ctrl, 32'd1);
        repeat (4) @(posedge clk);
        bypass_exp = 1'b1;
        pay_hold = 1'b0;
        repeat (100) @(posedge clk);
        pay_hold = 1'b1;
        apb_write(reg_ctrl, 32'd0);
        repeat (4) @(posedge clk);
        bypass_exp = 1'b0;
        pay_hold = 1'b0;
        repeat (100) @(posedge clk);
        finish_test("payload");

        apb_write(reg_hdr_err, 32'd0);
        hold_chk = 1'b1;
        inject(15, 1);
        hold_chk = 1'b0;
        apb_read(reg_hdr_err, rd, err);
        check_equal("reg_hdr_err", 32'd15, rd);
        apb_read(reg_lock_loss, rd, err);
        loss_before = int'(rd);
        // sixteen errors in one sync window drop the lock
        inject(16, 1);
        check_true(!block_lock, "block lock kept after 16 bad headers");
        wait_lock(1'b1, acq_blocks);
        check_true(block_lock, "block lock not reacquired");
        apb_read(reg_lock_loss, rd, err);
        check_equal("reg_lock_loss", 32'(loss_before + 1), rd);
        finish_test("lock_hold_loss");

        while (!armed) @(posedge clk);
        hold_chk = 1'b1;
        bad_gap = 6;
        bad_req = bad_sent + 80;
        while (!hi_ber && bad_sent < bad_req) @(posedge clk);
        repeat (ber_window + 4) @(posedge clk);
        check_true(hi_ber, "hi_ber not raised by spread header errors");
        apb_read(reg_status, rd, err);
        check_equal("reg_status", {30'd0, hi_ber, block_lock}, rd);
        while (bad_sent < bad_req) @(posedge clk);
        repeat (3 * ber_window) @(posedge clk);
        hold_chk = 1'b0;
        check_true(!hi_ber, "hi_ber not cleared after a clean window");
        finish_test("ber");

        apb_read(8'h20, rd, err);
        check_true(err, "no pslverr on an unmapped read");
        apb_write(reg_hdr_err, 32'd0);
        apb_read(reg_hdr_err, rd, err);
        check_equal("reg_hdr_err", 32'd0, rd);
        apb_read(reg_status, rd, err);
        check_equal("reg_status", {30'd0, hi_ber, block_lock}, rd);
        finish_test("apb");

        $display("summary: %0d passing, %0d failing", tests_ok, tests_bad);
        if (tests_bad == 0 && errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== phy_rx_top.f ====
logic/phy_rx_pkg.sv
logic/rx_bitslip_aligner.sv
logic/rx_frame_sync.sv
logic/rx_descrambler.sv
logic/rx_ber_monitor.sv
logic/rx_status_regs.sv
logic/phy_rx_top.sv
test/phy_rx_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Verilator build and run of the receive PCS testbench
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 -f phy_rx_top.f --top-module phy_rx_tb \
    -o phy_rx_sim > build.log 2>&1 \
    && ./obj_dir/phy_rx_sim > sim.log 2>&1 \
    || { echo "build or run error"; cat build.log sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "^all tests passed$" sim.log && exit 0 || exit 1
